// File: rtl/ask_pkg.sv
package ask_pkg;

	// ********************
	// sample format
	// ********************

	// decision variable, error and reference level are 1s17
	localparam int DV_W = 18;
	localparam int FRAC_W = DV_W - 1;

	// largest block is 2^8 symbols
	localparam int MAX_LOG2_BLOCK = 8;

	// squared error after dropping FRAC_W fraction bits
	localparam int SQ_W = 2 * DV_W - FRAC_W;

	typedef logic signed [DV_W-1:0] dv_t;

	// ********************
	// accumulator types
	// ********************

	// error sum with room for a full block of growth
	typedef logic signed [DV_W+MAX_LOG2_BLOCK-1:0] err_sum_t;

	// squared error sum in 1s17 power units
	typedef logic [SQ_W+MAX_LOG2_BLOCK-1:0] sq_sum_t;

	// four-level decision code
	typedef enum logic [1:0] {
		SL_M3 = 2'b00,
		SL_M1 = 2'b01,
		SL_P1 = 2'b10,
		SL_P3 = 2'b11
	} slice_t;

endpackage

// File: rtl/ask_quality_top.sv
`timescale 1ns/1ns

module ask_quality_top #(
	parameter int LOG2_BLOCK = 4
) (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     sym_clk_en,
	input  ask_pkg::dv_t             dec_var,
	output ask_pkg::slice_t          slice,
	output logic                     slice_valid,
	output ask_pkg::dv_t             ref_lvl,
	output ask_pkg::dv_t             err_mean,
	output logic [ask_pkg::SQ_W-1:0] err_var,
	output logic [ask_pkg::SQ_W-1:0] sig_pwr,
	output logic                     block_done
);

	import ask_pkg::*;

	dv_t mag_avg;
	logic last_sym;
	dv_t err;
	logic [SQ_W-1:0] err_sq;
	logic err_valid;
	logic err_last;
	err_sum_t err_ext;
	sq_sum_t err_sq_ext;
	err_sum_t err_avg;
	sq_sum_t sq_avg;
	logic avg_valid;

	// ********************
	// symbol path
	// ********************

	ref_level_est #(
		.LOG2_BLOCK (LOG2_BLOCK)
	) u_ref_level_est (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.sym_clk_en (sym_clk_en),
		.dec_var    (dec_var),
		.ref_lvl    (ref_lvl),
		.mag_avg    (mag_avg),
		.last_sym   (last_sym)
	);

	slicer_mapper u_slicer_mapper (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.sym_clk_en  (sym_clk_en),
		.dec_var     (dec_var),
		.ref_lvl     (ref_lvl),
		.mag_avg     (mag_avg),
		.last_sym    (last_sym),
		.slice       (slice),
		.slice_valid (slice_valid),
		.err         (err),
		.err_sq      (err_sq),
		.err_valid   (err_valid),
		.err_last    (err_last)
	);

	// ********************
	// block accumulators
	// ********************

	// sign extend the error, zero extend its square
	assign err_ext    = err_sum_t'(err);
	assign err_sq_ext = sq_sum_t'(err_sq);

	block_accum #(
		.LOG2_BLOCK (LOG2_BLOCK),
		.acc_t      (err_sum_t)
	) u_err_accum (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.sample_valid (err_valid),
		.sample_last  (err_last),
		.sample       (err_ext),
		.avg          (err_avg),
		.avg_valid    (avg_valid)
	);

	// pulses with u_err_accum so its valid stays open
	block_accum #(
		.LOG2_BLOCK (LOG2_BLOCK),
		.acc_t      (sq_sum_t)
	) u_sq_accum (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.sample_valid (err_valid),
		.sample_last  (err_last),
		.sample       (err_sq_ext),
		.avg          (sq_avg),
		.avg_valid    ()
	);

	quality_combine u_quality_combine (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.avg_valid  (avg_valid),
		.err_avg    (err_avg),
		.sq_avg     (sq_avg),
		.ref_lvl    (ref_lvl),
		.err_mean   (err_mean),
		.err_var    (err_var),
		.sig_pwr    (sig_pwr),
		.block_done (block_done)
	);

endmodule

// File: rtl/block_accum.sv
`timescale 1ns/1ns

module block_accum #(
	parameter int  LOG2_BLOCK = 4,
	parameter type acc_t      = logic signed [31:0]
) (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic sample_valid,
	input  logic sample_last,
	input  acc_t sample,
	output acc_t avg,
	output logic avg_valid
);

	acc_t acc_sum;
	acc_t total;

	// ********************
	// running sum
	// ********************

	// sum including the current sample
	assign total = acc_sum + sample;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_sum   <= '0;
			avg       <= '0;
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= sample_valid & sample_last;
			if (sample_valid) begin
				if (sample_last) begin
					// arithmetic for signed acc_t, logical otherwise
					avg     <= total >>> LOG2_BLOCK;
					acc_sum <= '0;
				end else begin
					acc_sum <= total;
				end
			end
		end
	end

endmodule

// File: rtl/quality_combine.sv
`timescale 1ns/1ns

module quality_combine (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     avg_valid,
	input  ask_pkg::err_sum_t        err_avg,
	input  ask_pkg::sq_sum_t         sq_avg,
	input  ask_pkg::dv_t             ref_lvl,
	output ask_pkg::dv_t             err_mean,
	output logic [ask_pkg::SQ_W-1:0] err_var,
	output logic [ask_pkg::SQ_W-1:0] sig_pwr,
	output logic                     block_done
);

	import ask_pkg::*;

	dv_t mean_c;
	logic signed [2*DV_W-1:0] mean_sq_full;
	logic [SQ_W-1:0] mean_sq;
	logic [SQ_W-1:0] var_c;
	// 5 * ref^2 needs three more bits
	logic signed [2*DV_W+2:0] pwr_full;

	// ********************
	// block statistics
	// ********************

	// mean of a block always fits the sample width
	assign mean_c = dv_t'(err_avg);

	assign mean_sq_full = mean_c * mean_c;
	assign mean_sq = mean_sq_full[2*DV_W-1:FRAC_W];

	// variance from E[e^2] minus mean^2
	assign var_c = (sq_avg > sq_sum_t'(mean_sq)) ? SQ_W'(sq_avg - sq_sum_t'(mean_sq)) : '0;

	// 4-ASK average power is 5a^2
	assign pwr_full = ref_lvl * ref_lvl * 5;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			err_mean   <= '0;
			err_var    <= '0;
			sig_pwr    <= '0;
			block_done <= 1'b0;
		end else begin
			block_done <= avg_valid;
			if (avg_valid) begin
				err_mean <= mean_c;
				err_var  <= var_c;
				sig_pwr  <= pwr_full[2*DV_W-1:FRAC_W];
			end
		end
	end

endmodule

// File: rtl/ref_level_est.sv
`timescale 1ns/1ns

module ref_level_est #(
	parameter int LOG2_BLOCK = 4
) (
	input  logic        sys_clk,
	input  logic        rst_n,
	input  logic        sym_clk_en,
	input  ask_pkg::dv_t dec_var,
	output ask_pkg::dv_t ref_lvl,
	output ask_pkg::dv_t mag_avg,
	output logic        last_sym
);

	import ask_pkg::*;

	// index of the final symbol in a block
	localparam logic [MAX_LOG2_BLOCK-1:0] BLOCK_MAX = MAX_LOG2_BLOCK'((1 << LOG2_BLOCK) - 1);

	logic [MAX_LOG2_BLOCK-1:0] sym_cnt;
	logic [DV_W+MAX_LOG2_BLOCK-1:0] mag_sum;
	logic [DV_W+MAX_LOG2_BLOCK-1:0] mag_sum_next;
	logic [DV_W-1:0] mag;
	dv_t avg_c;

	// ********************
	// magnitude and sum
	// ********************

	// |dec_var| as unsigned, full scale negative gives 2^17
	assign mag = dec_var[DV_W-1] ? DV_W'(-dec_var) : DV_W'(dec_var);

	assign mag_sum_next = mag_sum + (DV_W + MAX_LOG2_BLOCK)'(mag);

	// block average of the magnitude
	assign avg_c = dv_t'(mag_sum_next >> LOG2_BLOCK);

	// high while the next strobe closes the block
	assign last_sym = (sym_cnt == BLOCK_MAX);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			sym_cnt <= '0;
			mag_sum <= '0;
			mag_avg <= '0;
			ref_lvl <= '0;
		end else if (sym_clk_en) begin
			if (last_sym) begin
				// block closes here
				sym_cnt <= '0;
				mag_sum <= '0;
				mag_avg <= avg_c;
				// outer level is 3a and avg mag is 2a
				ref_lvl <= avg_c >>> 1;
			end else begin
				sym_cnt <= sym_cnt + 1'b1;
				mag_sum <= mag_sum_next;
			end
		end
	end

endmodule

// File: rtl/slicer_mapper.sv
`timescale 1ns/1ns

module slicer_mapper (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     sym_clk_en,
	input  ask_pkg::dv_t             dec_var,
	input  ask_pkg::dv_t             ref_lvl,
	input  ask_pkg::dv_t             mag_avg,
	input  logic                     last_sym,
	output ask_pkg::slice_t          slice,
	output logic                     slice_valid,
	output ask_pkg::dv_t             err,
	output logic [ask_pkg::SQ_W-1:0] err_sq,
	output logic                     err_valid,
	output logic                     err_last
);

	import ask_pkg::*;

	slice_t slice_c;
	dv_t neg_thr;
	dv_t err_c;
	// two guard bits for 3a and the difference
	logic signed [DV_W+1:0] ref_x1;
	logic signed [DV_W+1:0] ref_x3;
	logic signed [DV_W+1:0] mapped;
	logic signed [DV_W+1:0] diff;
	logic signed [2*DV_W-1:0] sq_full;
	logic valid_q;

	// ********************
	// decision
	// ********************

	assign neg_thr = -mag_avg;

	// ties go to the upper level
	always_comb begin
		if (dec_var >= mag_avg)
			slice_c = SL_P3;
		else if (dec_var >= 0)
			slice_c = SL_P1;
		else if (dec_var >= neg_thr)
			slice_c = SL_M1;
		else
			slice_c = SL_M3;
	end

	// ideal level for the decision
	assign ref_x1 = (DV_W + 2)'(ref_lvl);
	assign ref_x3 = (ref_x1 <<< 1) + ref_x1;

	always_comb begin
		case (slice_c)
			SL_P3:   mapped = ref_x3;
			SL_P1:   mapped = ref_x1;
			SL_M1:   mapped = -ref_x1;
			default: mapped = -ref_x3;
		endcase
	end

	assign diff = (DV_W + 2)'(dec_var) - mapped;
	assign err_c = dv_t'(diff);

	// full product, then drop the fraction bits
	assign sq_full = err_c * err_c;

	// ********************
	// output registers
	// ********************

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q  <= 1'b0;
			err_last <= 1'b0;
			slice    <= SL_M3;
			err      <= '0;
			err_sq   <= '0;
		end else begin
			valid_q  <= sym_clk_en;
			err_last <= sym_clk_en & last_sym;
			if (sym_clk_en) begin
				slice  <= slice_c;
				err    <= err_c;
				err_sq <= sq_full[2*DV_W-1:FRAC_W];
			end
		end
	end

	// one flag, two names
	assign slice_valid = valid_q;
	assign err_valid   = valid_q;

endmodule

// File: sim/ask_checker.sv
`timescale 1ns/1ns

module ask_checker (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  ask_pkg::slice_t          slice,
	input  logic                     slice_valid,
	input  ask_pkg::dv_t             ref_lvl,
	input  ask_pkg::dv_t             err_mean,
	input  logic [ask_pkg::SQ_W-1:0] err_var,
	input  logic [ask_pkg::SQ_W-1:0] sig_pwr,
	input  logic                     block_done,
	output int                       error_count,
	output int                       slice_count,
	output int                       block_count
);

	import ask_pkg::*;

	// expected values in strobe order
	logic [1:0] exp_slice_q[$];
	// block results, all zero extended to SQ_W bits
	logic [SQ_W-1:0] exp_ref_q[$];
	logic [SQ_W-1:0] exp_mean_q[$];
	logic [SQ_W-1:0] exp_var_q[$];
	logic [SQ_W-1:0] exp_pwr_q[$];

	logic [1:0] got_code;
	logic [1:0] exp_code;
	logic [SQ_W-1:0] e_ref;
	logic [SQ_W-1:0] e_mean;
	logic [SQ_W-1:0] e_var;
	logic [SQ_W-1:0] e_pwr;

	initial begin
		error_count = 0;
		slice_count = 0;
		block_count = 0;
	end

	// ********************
	// expected value intake
	// ********************

	task automatic add_slice(input logic [1:0] code);
		exp_slice_q.push_back(code);
	endtask

	task automatic add_block(
		input logic [SQ_W-1:0] r,
		input logic [SQ_W-1:0] m,
		input logic [SQ_W-1:0] v,
		input logic [SQ_W-1:0] p
	);
		exp_ref_q.push_back(r);
		exp_mean_q.push_back(m);
		exp_var_q.push_back(v);
		exp_pwr_q.push_back(p);
	endtask

	// one field of a block result
	task automatic compare_field(
		input string           name,
		input int              idx,
		input logic [SQ_W-1:0] got,
		input logic [SQ_W-1:0] exp
	);
		if (got !== exp) begin
			$display("FAIL %s block %0d: got %h expected %h", name, idx, got, exp);
			error_count++;
		end
	endtask

	// ********************
	// comparisons
	// ********************

	// outputs are registered, so the falling edge sees them settled
	always @(negedge sys_clk) begin
		if (rst_n && slice_valid) begin
			if (exp_slice_q.size() == 0) begin
				$display("slice_valid pulsed after every expected slice was used");
				error_count++;
			end else begin
				exp_code = exp_slice_q.pop_front();
				got_code = slice;
				if (got_code !== exp_code) begin
					$display("FAIL slice symbol %0d: got %h expected %h",
						slice_count, got_code, exp_code);
					error_count++;
				end
			end
			slice_count++;
		end
	end

	// block results held from block_done on
	always @(negedge sys_clk) begin
		if (rst_n && block_done) begin
			if (exp_ref_q.size() == 0) begin
				$display("block_done pulsed after every expected block was used");
				error_count++;
			end else begin
				e_ref  = exp_ref_q.pop_front();
				e_mean = exp_mean_q.pop_front();
				e_var  = exp_var_q.pop_front();
				e_pwr  = exp_pwr_q.pop_front();
				compare_field("ref_lvl", block_count, $unsigned(ref_lvl), e_ref);
				compare_field("err_mean", block_count, $unsigned(err_mean), e_mean);
				compare_field("err_var", block_count, err_var, e_var);
				compare_field("sig_pwr", block_count, sig_pwr, e_pwr);
			end
			block_count++;
		end
	end

endmodule

// File: sim/ask_quality_properties.sv
`timescale 1ns/1ns

module ask_quality_properties (
	input logic sys_clk,
	input logic rst_n,
	input logic sym_clk_en,
	input logic slice_valid,
	input logic block_done
);

	// assertion failures so far
	int assert_fails = 0;

	// ********************
	// output timing
	// ********************

	// every strobe gives a slice one cycle later
	a_slice_after_strobe: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		sym_clk_en |=> slice_valid
	) else begin
		$error("slice_valid missing one cycle after sym_clk_en");
		assert_fails++;
	end

	// no slice without a strobe the cycle before
	a_no_stray_slice: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		slice_valid |-> $past(sym_clk_en)
	) else begin
		$error("slice_valid high without a preceding sym_clk_en");
		assert_fails++;
	end

	// slice at t+1, block_done at t+3
	a_done_after_slice: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		block_done |-> $past(slice_valid, 2)
	) else begin
		$error("block_done without slice_valid two cycles earlier");
		assert_fails++;
	end

	// quiet outputs while reset is held
	a_quiet_in_reset: assert property (
		@(posedge sys_clk)
		!rst_n |-> (!slice_valid && !block_done)
	) else begin
		$error("slice_valid or block_done high during reset");
		assert_fails++;
	end

endmodule

bind ask_quality_top ask_quality_properties u_properties (
	.sys_clk     (sys_clk),
	.rst_n       (rst_n),
	.sym_clk_en  (sym_clk_en),
	.slice_valid (slice_valid),
	.block_done  (block_done)
);

// File: sim/ask_vectors.txt
# S <dec_var, 18-bit hex> <slice: 0 M3, 1 M1, 2 P1, 3 P3>
# B <ref_lvl> <err_mean> <err_var> <sig_pwr>, all hex
# block 1: levels still 0, so sign alone decides
S 0C000 3
S 3C000 0
S 04000 3
S 34000 0
S 34000 0
S 04000 3
S 0C000 3
S 3C000 0
S 04000 3
S 0C000 3
S 3C000 0
S 34000 0
S 3C000 0
S 34000 0
S 0C000 3
S 04000 3
B 04000 00000 02800 02800
# block 2: errors of -1023 and -1024, mean squared exceeds the square mean
S 0BC01 3
S 33C00 0
S 03C01 2
S 3BC00 1
S 0BC00 3
S 3BC01 1
S 33C01 0
S 03C00 2
S 03C01 2
S 33C00 0
S 0BC01 3
S 3BC00 1
S 3BC01 1
S 03C00 2
S 33C01 0
S 0BC00 3
B 04000 3FC00 00000 02800
# block 3: noisy, with ties at +2a, 0 and -2a
S 08000 3
S 36000 0
S 00000 2
S 3D000 1
S 0C800 3
S 38000 1
S 05000 2
S 35000 0
S 3D800 1
S 0D000 3
S 04800 2
S 34800 0
S 0B800 3
S 3B800 1
S 03800 2
S 33000 0
B 03CC0 3FA80 001D7 0240A

// File: sim/clk_rst_gen.sv
`timescale 1ns/1ns

module clk_rst_gen #(
	parameter int CLK_PERIOD = 8,
	parameter int RST_CYCLES = 2
) (
	output logic sys_clk,
	output logic rst_n
);

	// free running clock, first rising edge at half a period
	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// reset low over RST_CYCLES rising edges
	// released on a falling edge, away from the DUT's active edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;
	end

endmodule

// File: sim/tb_ask_quality.sv
`timescale 1ns/1ns

module tb_ask_quality;

	import ask_pkg::*;

	localparam int LOG2_BLOCK = 4;
	localparam int BLOCK_LEN = 1 << LOG2_BLOCK;
	localparam int N_SYM = 48;
	// a strobe plus at most three idle cycles per symbol, then margin
	localparam int TIMEOUT_CYCLES = N_SYM * 4 + 50;

	logic sys_clk;
	logic rst_n;
	logic sym_clk_en;
	dv_t dec_var;
	slice_t slice;
	logic slice_valid;
	dv_t ref_lvl;
	dv_t err_mean;
	logic [SQ_W-1:0] err_var;
	logic [SQ_W-1:0] sig_pwr;
	logic block_done;

	int error_count;
	int slice_count;
	int block_count;
	int run_errors;
	int cycle_cnt = 0;
	int n_sym;
	int n_blk;
	dv_t sym_dv [N_SYM];
	logic [31:0] lfsr;

	// ********************
	// instances
	// ********************

	clk_rst_gen u_clk_rst_gen (
		.sys_clk (sys_clk),
		.rst_n   (rst_n)
	);

	ask_quality_top #(
		.LOG2_BLOCK (LOG2_BLOCK)
	) u_ask_quality_top (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.sym_clk_en  (sym_clk_en),
		.dec_var     (dec_var),
		.slice       (slice),
		.slice_valid (slice_valid),
		.ref_lvl     (ref_lvl),
		.err_mean    (err_mean),
		.err_var     (err_var),
		.sig_pwr     (sig_pwr),
		.block_done  (block_done)
	);

	ask_checker u_checker (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.slice       (slice),
		.slice_valid (slice_valid),
		.ref_lvl     (ref_lvl),
		.err_mean    (err_mean),
		.err_var     (err_var),
		.sig_pwr     (sig_pwr),
		.block_done  (block_done),
		.error_count (error_count),
		.slice_count (slice_count),
		.block_count (block_count)
	);

	// ********************
	// helpers
	// ********************

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// idle gap of 0..3 cycles, one step per bit
	task automatic pick_gap(output int gap);
		lfsr = lfsr_next(lfsr);
		gap = int'(lfsr[0]);
		lfsr = lfsr_next(lfsr);
		gap = gap + 2 * int'(lfsr[0]);
	endtask

	// S lines feed the stimulus and the slice queue, B lines the block queue
	task automatic load_vectors();
		int fd;
		int code;
		logic [8*8-1:0] tag;
		logic [8*160-1:0] rest;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		fd = $fopen("sim/ask_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file sim/ask_vectors.txt");
			run_errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1)
				break;
			if (tag == "#") begin
				code = $fgets(rest, fd);
			end else if (tag == "S") begin
				code = $fscanf(fd, "%h %h", f0, f1);
				if (n_sym < N_SYM) begin
					sym_dv[n_sym] = dv_t'(f0[DV_W-1:0]);
					u_checker.add_slice(f1[1:0]);
				end else begin
					$display("vector file holds more symbols than the testbench drives");
					run_errors++;
				end
				n_sym++;
			end else if (tag == "B") begin
				code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
				u_checker.add_block(f0[SQ_W-1:0], f1[SQ_W-1:0], f2[SQ_W-1:0], f3[SQ_W-1:0]);
				n_blk++;
			end else begin
				$display("vector file has a line of unknown type");
				run_errors++;
			end
		end
		$fclose(fd);
	endtask

	// one strobe per symbol, driven on the falling edge
	task automatic drive_symbols();
		int gap;
		int count;
		count = (n_sym < N_SYM) ? n_sym : N_SYM;
		for (int i = 0; i < count; i++) begin
			@(negedge sys_clk);
			sym_clk_en = 1'b1;
			dec_var = sym_dv[i];
			pick_gap(gap);
			// last two of a block run straight into the next block
			if ((i % BLOCK_LEN) >= BLOCK_LEN - 2)
				gap = 0;
			if (gap != 0 || i == count - 1) begin
				@(negedge sys_clk);
				sym_clk_en = 1'b0;
				if (gap > 1)
					repeat (gap - 1) @(negedge sys_clk);
			end
		end
	endtask

	// ********************
	// run control
	// ********************

	always @(posedge sys_clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timed out after %0d cycles before all blocks were reported", cycle_cnt);
		$display("errors: %0d checker, %0d assertion, %0d run", error_count,
			u_ask_quality_top.u_properties.assert_fails, run_errors);
		$display("Checks failed");
		$finish;
	end

	initial begin
		sym_clk_en = 1'b0;
		dec_var = '0;
		run_errors = 0;
		n_sym = 0;
		n_blk = 0;
		lfsr = 32'h9996_2332;
		load_vectors();
		if (n_sym == 0) begin
			$display("no symbols were read from the vector file");
			run_errors++;
		end
		wait (rst_n === 1'b1);
		drive_symbols();
		while (block_count < n_blk)
			@(negedge sys_clk);
		// room for a stray late pulse
		repeat (4) @(negedge sys_clk);
		if (slice_count != n_sym) begin
			$display("DUT reported %0d slices for %0d symbols", slice_count, n_sym);
			run_errors++;
		end
		if (block_count != n_blk) begin
			$display("DUT reported %0d blocks, %0d expected", block_count, n_blk);
			run_errors++;
		end
		$display("errors: %0d checker, %0d assertion, %0d run", error_count,
			u_ask_quality_top.u_properties.assert_fails, run_errors);
		if (error_count + run_errors + u_ask_quality_top.u_properties.assert_fails == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: vlog.f
rtl/ask_pkg.sv
rtl/ref_level_est.sv
rtl/slicer_mapper.sv
rtl/block_accum.sv
rtl/quality_combine.sv
rtl/ask_quality_top.sv
sim/clk_rst_gen.sv
sim/ask_checker.sv
sim/ask_quality_properties.sv
sim/tb_ask_quality.sv
